// File: hdl/pgwr_params.svh
/*
 * sizes, base addresses and bus widths of the page-table write manager
 * include wherever a table size or address is needed
 */
`ifndef PGWR_PARAMS_SVH
`define PGWR_PARAMS_SVH

// table sizes in entries, index 0 is NULL so entries count from 1
`define PGWR_ATT_ENTRIES 16
`define PGWR_LIST_ENTRIES 8

// byte base addresses of the two tables
`define PGWR_ATT_BASE 64'h0000_0000_8000_0000
`define PGWR_LIST_BASE 64'h0000_0000_8001_0000

`define PGWR_PTR_W 24 // list pointer, 3 bytes
`define PGWR_LINE_W 512 // one cache line per write
`define PGWR_STRB_W 64
`define PGWR_ADDR_W 64

`endif

// File: hdl/pgwr_pkg.sv
/*
 * types of the page-table write manager: list ids, ATT status codes,
 * table entry layouts and the structs carried on its ports
 */
`include "pgwr_params.svh"

package pgwr_pkg;

	typedef logic [`PGWR_PTR_W-1:0] ptr_t; // list entry index
	typedef logic [39:0] way_t;

	localparam ptr_t NULL_PTR = '0;

	typedef enum logic [1:0] {
		LST_FREE   = 2'd0,
		LST_UNCOMP = 2'd1,
		LST_INCOMP = 2'd2 // pushed at the head
	} list_id_e;

	typedef enum logic [1:0] {
		STS_DALLOC = 2'd0,
		STS_UNCOMP = 2'd1,
		STS_INCOMP = 2'd2,
		STS_COMP   = 2'd3
	} att_sts_e;

	// one ATT entry, eight per line
	typedef struct packed {
		logic [21:0] zpd_cnt; // zero-page count
		way_t        way;
		att_sts_e    sts;
	} att_entry_t;

	// one list entry, four per line, next in the low 3 bytes
	typedef struct packed {
		logic [15:0] rsvd;
		way_t        way;
		ptr_t        att_id;
		ptr_t        prev;
		ptr_t        next;
	} list_entry_t;

	typedef struct packed {
		logic [`PGWR_ADDR_W-1:0] addr;
	} aw_pld_t;

	typedef struct packed {
		logic [`PGWR_LINE_W-1:0] data;
		logic [`PGWR_STRB_W-1:0] strb;
	} w_pld_t;

	// table update request from the page-read side
	typedef struct packed {
		ptr_t     att_id;
		way_t     way;
		ptr_t     next;   // next pointer of the moved entry
		ptr_t     lst_id; // moved entry, refilled from the source head on accept
		list_id_e src;
		list_id_e dst;
	} tbl_upd_t;

	// heads and tails indexed by list_id_e
	typedef struct packed {
		ptr_t [2:0] head;
		ptr_t [2:0] tail;
	} list_ht_t;

	typedef struct packed {
		logic       bvalid;
		logic [1:0] bresp; // 0 is OKAY
	} wr_resp_t;

	typedef enum logic [1:0] {
		ATT_WR   = 2'd0,
		SRC_POP  = 2'd1,
		DST_SELF = 2'd2,
		DST_LINK = 2'd3
	} upd_step_e;

endpackage

// File: hdl/wr_chan_hold.sv
/*
 * holds one write channel payload and its valid until the ready handshake
 * used for both the AW and the W channel
 */
`timescale 1ns/1ps

module wr_chan_hold #(
	parameter type payload_t = logic
) (
	input  logic     clk_i,
	input  logic     rst_ni,
	input  logic     load,
	input  payload_t pld_in,
	input  logic     ready,
	output payload_t pld,
	output logic     valid,
	output logic     busy   // still holding after this cycle
);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) valid <= 1'b0;
		else if (load) valid <= 1'b1;
		else if (ready) valid <= 1'b0; // handshake done
	end

	always_ff @(posedge clk_i) begin
		if (load) pld <= pld_in;
	end

	assign busy = valid && !ready;

endmodule

// File: hdl/bresp_tracker.sv
/*
 * counts accepted write addresses and OKAY responses of one operation
 * all_done is high once every issued write has its response
 */
`timescale 1ns/1ps

module bresp_tracker
	import pgwr_pkg::*;
(
	input  logic     clk_i,
	input  logic     rst_ni,
	input  logic     clear,  // held while the FSM is idle
	input  logic     aw_fire,
	input  wr_resp_t resp,
	output logic     all_done
);

	logic [6:0] aw_cnt;
	logic [6:0] ok_cnt;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			aw_cnt <= '0;
			ok_cnt <= '0;
		end else if (clear) begin
			aw_cnt <= '0;
			ok_cnt <= '0;
		end else begin
			if (aw_fire) aw_cnt <= aw_cnt + 1'b1;
			if (resp.bvalid && resp.bresp == 2'b00) ok_cnt <= ok_cnt + 1'b1; // in order
		end
	end

	assign all_done = (aw_cnt == ok_cnt) && (aw_cnt != '0);

endmodule

// File: hdl/list_ht_regs.sv
/*
 * head and tail registers of the free, uncompressed and incompressible lists
 * updated on each committed pop or push and at the end of list init
 */
`timescale 1ns/1ps
`include "pgwr_params.svh"

module list_ht_regs
	import pgwr_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_ni,
	input  logic      commit,
	input  upd_step_e step,
	input  tbl_upd_t  upd,
	input  logic      init_list_done_set, // level, acted on at its rising edge
	output list_ht_t  lists
);

	logic set_q;
	logic tail_push;

	assign tail_push = upd.dst != LST_INCOMP;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			lists <= '0; // all NULL
			set_q <= 1'b0;
		end else begin
			set_q <= init_list_done_set;
			if (init_list_done_set && !set_q) begin
				lists.head[LST_FREE] <= ptr_t'(1);
				lists.tail[LST_FREE] <= ptr_t'(`PGWR_LIST_ENTRIES);
			end else if (commit) begin
				case (step)
					ATT_WR: begin // single entry source, emptied
						lists.head[upd.src] <= NULL_PTR;
						lists.tail[upd.src] <= NULL_PTR;
					end
					SRC_POP: lists.head[upd.src] <= upd.next;
					default: begin // push of the moved entry
						if (lists.head[upd.dst] == NULL_PTR) begin
							lists.head[upd.dst] <= upd.lst_id;
							lists.tail[upd.dst] <= upd.lst_id;
						end else if (tail_push) begin
							lists.tail[upd.dst] <= upd.lst_id;
						end else begin
							lists.head[upd.dst] <= upd.lst_id;
						end
					end
				endcase
			end
		end
	end

endmodule

// File: hdl/init_wr_gen.sv
/*
 * address, data and strobes of one initialization write from the entry index
 * ATT entries go out as DALLOC and list entries are chained into one free list
 */
`timescale 1ns/1ps
`include "pgwr_params.svh"

module init_wr_gen
	import pgwr_pkg::*;
(
	input  ptr_t    entry_idx,      // 1 based
	input  logic    init_list_mode,
	output aw_pld_t aw,
	output w_pld_t  w
);

	ptr_t        idx0;  // 0 based
	logic [2:0]  aslot; // 8 ATT entries per line
	logic [1:0]  lslot; // 4 list entries per line
	list_entry_t lst_ent;

	assign idx0 = entry_idx - 1'b1;
	assign aslot = idx0[2:0];
	assign lslot = idx0[1:0];

	always_comb begin
		lst_ent = '0;
		lst_ent.way = way_t'(idx0);
		lst_ent.prev = idx0; // NULL for the first entry
		lst_ent.next = (entry_idx == ptr_t'(`PGWR_LIST_ENTRIES)) ? NULL_PTR : entry_idx + 1'b1;
		w = '0;
		if (init_list_mode) begin
			aw.addr = `PGWR_LIST_BASE + (`PGWR_ADDR_W'(idx0[`PGWR_PTR_W-1:2]) << 6);
			w.data[lslot*128 +: 128] = lst_ent;
			w.strb[lslot*16 +: 16] = '1; // whole 16B entry
		end else begin
			aw.addr = `PGWR_ATT_BASE + (`PGWR_ADDR_W'(idx0[`PGWR_PTR_W-1:3]) << 6);
			w.data[aslot*64 +: 2] = STS_DALLOC; // status in the low bits with count and way zero
			w.strb[aslot*8 +: 8] = '1;
		end
	end

endmodule

// File: hdl/tbl_wr_gen.sv
/*
 * writes of one table update step: ATT entry, pop of the source head,
 * the moved entry itself and the link from its new neighbour
 */
`timescale 1ns/1ps
`include "pgwr_params.svh"

module tbl_wr_gen
	import pgwr_pkg::*;
(
	input  upd_step_e step,
	input  tbl_upd_t  upd,
	input  list_ht_t  lists,
	output aw_pld_t   aw,
	output w_pld_t    w
);

	logic       tail_push; // UNCOMP takes tail pushes, INCOMP head pushes
	ptr_t       att0;
	logic [2:0] aslot;
	ptr_t       tgt;       // list entry touched by this step
	ptr_t       tgt0;
	logic [1:0] lslot;
	ptr_t       self_prev;
	ptr_t       self_next;
	att_entry_t att_ent;

	assign tail_push = upd.dst != LST_INCOMP;
	assign att0 = upd.att_id - 1'b1;
	assign aslot = att0[2:0];
	assign self_prev = tail_push ? lists.tail[upd.dst] : NULL_PTR;
	assign self_next = tail_push ? NULL_PTR : lists.head[upd.dst];

	always_comb begin
		case (step)
			SRC_POP:  tgt = upd.next; // new source head
			DST_SELF: tgt = upd.lst_id;
			default:  tgt = tail_push ? lists.tail[upd.dst] : lists.head[upd.dst];
		endcase
	end

	assign tgt0 = tgt - 1'b1;
	assign lslot = tgt0[1:0];

	always_comb begin
		att_ent = '0;
		att_ent.way = upd.way;
		if (upd.src == LST_FREE && upd.dst == LST_UNCOMP) att_ent.sts = STS_UNCOMP;
		else if (upd.src == LST_UNCOMP && upd.dst == LST_INCOMP) att_ent.sts = STS_INCOMP;
		else att_ent.sts = STS_COMP; // uncomp to uncomp, page got compressed
	end

	always_comb begin
		w = '0;
		if (step == ATT_WR) begin
			aw.addr = `PGWR_ATT_BASE + (`PGWR_ADDR_W'(att0[`PGWR_PTR_W-1:3]) << 6);
			w.data[aslot*64 +: 64] = att_ent;
			w.strb[aslot*8 +: 8] = '1;
		end else begin
			aw.addr = `PGWR_LIST_BASE + (`PGWR_ADDR_W'(tgt0[`PGWR_PTR_W-1:2]) << 6);
			case (step)
				SRC_POP: begin
					w.data[lslot*128 + 24 +: 24] = NULL_PTR; // prev only
					w.strb[lslot*16 + 3 +: 3] = '1;
				end
				DST_SELF: begin
					w.data[lslot*128 +: 72] = {upd.att_id, self_prev, self_next};
					w.strb[lslot*16 +: 9] = '1;
				end
				default: begin
					if (tail_push) begin // old tail next -> moved
						w.data[lslot*128 +: 24] = upd.lst_id;
						w.strb[lslot*16 +: 3] = '1;
					end else begin // old head prev -> moved
						w.data[lslot*128 + 24 +: 24] = upd.lst_id;
						w.strb[lslot*16 + 3 +: 3] = '1;
					end
				end
			endcase
		end
	end

endmodule

// File: hdl/pgwr_ctrl.sv
/*
 * control FSM of the page-table write manager: accepts init and update
 * strobes, issues one write at a time and raises the done flags
 */
`timescale 1ns/1ps
`include "pgwr_params.svh"

module pgwr_ctrl
	import pgwr_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_ni,
	input  logic      init_att,
	input  logic      init_list,
	input  logic      upd_valid,
	input  tbl_upd_t  upd_pkt,
	input  list_ht_t  lists,
	input  logic      aw_busy, // AW still held after this cycle
	input  logic      w_busy,
	input  logic      all_done,
	output logic      aw_load,
	output logic      w_load,
	output logic      use_init,
	output ptr_t      entry_idx,
	output logic      init_list_mode,
	output upd_step_e step,
	output tbl_upd_t  latched_upd,
	output logic      ht_commit,
	output logic      ready,
	output logic      init_att_done,
	output logic      init_list_done,
	output logic      upd_done
);

	typedef enum logic [2:0] {S_IDLE, S_ISSUE, S_AW, S_W, S_DRAIN} state_e;
	typedef enum logic [1:0] {OP_ATT, OP_LIST, OP_UPD} op_e;

	state_e state_q;
	op_e    op_q;
	logic   att_done_q;
	logic   list_done_q;
	logic   w_fire;     // W accepted this cycle
	logic   drain_fin;  // last response seen
	logic   src_single; // pop would empty the source list
	logic   dst_empty;
	ptr_t   last_ent;

	assign w_fire = (state_q == S_W) && !w_busy;
	assign drain_fin = (state_q == S_DRAIN) && all_done;
	assign last_ent = (op_q == OP_LIST) ? ptr_t'(`PGWR_LIST_ENTRIES) : ptr_t'(`PGWR_ATT_ENTRIES);
	assign src_single = lists.head[latched_upd.src] == lists.tail[latched_upd.src];
	assign dst_empty = lists.head[latched_upd.dst] == NULL_PTR;

	assign ready = state_q == S_IDLE;
	assign use_init = op_q != OP_UPD;
	assign init_list_mode = op_q == OP_LIST;
	assign aw_load = (state_q == S_ISSUE) && !aw_busy;
	assign w_load = (state_q == S_AW) && !aw_busy && !w_busy; // AW handshake this cycle
	assign upd_done = drain_fin && (op_q == OP_UPD);
	assign init_att_done = att_done_q || (drain_fin && op_q == OP_ATT);
	assign init_list_done = list_done_q || (drain_fin && op_q == OP_LIST);

	// pointer change of the step whose W just went out
	always_comb begin
		ht_commit = 1'b0;
		if (w_fire && op_q == OP_UPD) begin
			case (step)
				ATT_WR:   ht_commit = src_single; // pop skipped, list emptied
				SRC_POP:  ht_commit = 1'b1;
				DST_SELF: ht_commit = dst_empty;  // becomes head and tail
				default:  ht_commit = 1'b1;
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= S_IDLE;
			op_q <= OP_ATT;
			entry_idx <= '0;
			step <= ATT_WR;
			att_done_q <= 1'b0;
			list_done_q <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (init_att) begin // priority att, list, update
						op_q <= OP_ATT;
						entry_idx <= ptr_t'(1);
						state_q <= S_ISSUE;
					end else if (init_list) begin
						op_q <= OP_LIST;
						entry_idx <= ptr_t'(1);
						state_q <= S_ISSUE;
					end else if (upd_valid) begin
						op_q <= OP_UPD;
						step <= ATT_WR;
						state_q <= S_ISSUE;
					end
				end
				S_ISSUE: if (!aw_busy) state_q <= S_AW;
				S_AW:    if (!aw_busy) state_q <= S_W;
				S_W: begin
					if (w_fire) begin
						state_q <= S_ISSUE;
						if (op_q != OP_UPD) begin
							if (entry_idx == last_ent) state_q <= S_DRAIN;
							else entry_idx <= entry_idx + 1'b1;
						end else begin
							case (step)
								ATT_WR:  step <= src_single ? DST_SELF : SRC_POP;
								SRC_POP: step <= DST_SELF;
								DST_SELF: begin
									if (dst_empty) state_q <= S_DRAIN; // no neighbour to link
									else step <= DST_LINK;
								end
								default: state_q <= S_DRAIN;
							endcase
						end
					end
				end
				default: begin // S_DRAIN, wait for the last bresp
					if (all_done) begin
						state_q <= S_IDLE;
						if (op_q == OP_ATT) att_done_q <= 1'b1;
						if (op_q == OP_LIST) list_done_q <= 1'b1;
					end
				end
			endcase
		end
	end

	// request captured at accept, moved entry is the current source head
	always_ff @(posedge clk_i) begin
		if (ready && !init_att && !init_list && upd_valid) begin
			latched_upd <= upd_pkt;
			latched_upd.lst_id <= lists.head[upd_pkt.src];
		end
	end

endmodule

// File: hdl/pgwr_mngr.sv
/*
 * page-table write manager top: initializes the ATT and list tables and
 * moves entries between lists through a single outstanding write port
 */
`timescale 1ns/1ps

module pgwr_mngr
	import pgwr_pkg::*;
(
	input  logic     clk_i,
	input  logic     rst_ni,
	input  logic     init_att,
	input  logic     init_list,
	input  logic     upd_valid,
	input  tbl_upd_t upd_pkt,
	input  logic     awready,
	input  logic     wready,
	output aw_pld_t  aw,
	output logic     awvalid,
	output w_pld_t   w,
	output logic     wvalid,
	input  wr_resp_t resp,
	output list_ht_t lists,
	output logic     ready,
	output logic     init_att_done,
	output logic     init_list_done,
	output logic     upd_done
);

	logic      aw_load;
	logic      w_load;
	logic      aw_busy;
	logic      w_busy;
	logic      all_done;
	logic      use_init;
	logic      init_list_mode;
	logic      ht_commit;
	logic      aw_fire;
	ptr_t      entry_idx;
	upd_step_e step;
	tbl_upd_t  latched_upd;
	aw_pld_t   init_aw;
	aw_pld_t   tbl_aw;
	aw_pld_t   aw_src;
	w_pld_t    init_w;
	w_pld_t    tbl_w;
	w_pld_t    w_src;

	assign aw_src = use_init ? init_aw : tbl_aw; // payload source per operation
	assign w_src = use_init ? init_w : tbl_w;
	assign aw_fire = awvalid && awready;

	pgwr_ctrl u_ctrl (
		.clk_i, .rst_ni, .init_att, .init_list, .upd_valid, .upd_pkt, .lists,
		.aw_busy, .w_busy, .all_done, .aw_load, .w_load, .use_init, .entry_idx,
		.init_list_mode, .step, .latched_upd, .ht_commit, .ready,
		.init_att_done, .init_list_done, .upd_done
	);

	init_wr_gen u_init_wr_gen (.entry_idx, .init_list_mode, .aw(init_aw), .w(init_w));

	tbl_wr_gen u_tbl_wr_gen (.step, .upd(latched_upd), .lists, .aw(tbl_aw), .w(tbl_w));

	list_ht_regs u_list_ht_regs (
		.clk_i, .rst_ni, .commit(ht_commit), .step, .upd(latched_upd),
		.init_list_done_set(init_list_done), .lists
	);

	bresp_tracker u_bresp_tracker (.clk_i, .rst_ni, .clear(ready), .aw_fire, .resp, .all_done);

	wr_chan_hold #(.payload_t(aw_pld_t)) aw_hold (
		.clk_i, .rst_ni, .load(aw_load), .pld_in(aw_src), .ready(awready),
		.pld(aw), .valid(awvalid), .busy(aw_busy)
	);

	wr_chan_hold #(.payload_t(w_pld_t)) w_hold (
		.clk_i, .rst_ni, .load(w_load), .pld_in(w_src), .ready(wready),
		.pld(w), .valid(wvalid), .busy(w_busy)
	);

endmodule

// File: sim/tb_pgwr_mngr.sv
/*
 * testbench of the page-table write manager
 * byte memory model with random ready and response delays
 * random list moves checked against a reference model
 */
`timescale 1ns/1ps
`include "pgwr_params.svh"

module tb_pgwr_mngr
	import pgwr_pkg::*;
();

	localparam int N_UPD = 20;
	localparam int N_WR = `PGWR_ATT_ENTRIES + `PGWR_LIST_ENTRIES + (N_UPD + 1) * 4;
	localparam int CYC_LIMIT = N_WR * 12 + 400; // about 12 cycles per write in the worst case
	localparam int ATT_BYTES = `PGWR_ATT_ENTRIES * 8;
	localparam int LST_BYTES = `PGWR_LIST_ENTRIES * 16;

	logic     clk_i = 1'b0;
	logic     rst_ni;
	logic     init_att;
	logic     init_list;
	logic     upd_valid;
	tbl_upd_t upd_pkt;
	logic     awready = 1'b0; // memory side driven by the model below
	logic     wready = 1'b0;
	wr_resp_t resp = '0;
	aw_pld_t  aw;
	logic     awvalid;
	w_pld_t   w;
	logic     wvalid;
	list_ht_t lists;
	logic     ready;
	logic     init_att_done;
	logic     init_list_done;
	logic     upd_done;

	logic [7:0] att_mem [0:ATT_BYTES-1];
	logic [7:0] lst_mem [0:LST_BYTES-1];
	aw_pld_t    addr_q [$]; // accepted addresses still waiting for W
	int         b_q [$];    // pending response delays in order
	int         aw_dly = 0;
	int         w_dly = 0;
	logic       aw_hs;
	logic       w_hs;
	logic       nxt_bvalid;

	att_entry_t  model_att [1:`PGWR_ATT_ENTRIES];
	list_entry_t model_lst [1:`PGWR_LIST_ENTRIES];
	list_ht_t    model_ht;
	int          cnt [0:2]; // entries held per list

	integer   seed = 32'h1b34;
	int       err_cnt = 0;
	int       n_chk = 0;
	int       test_err0 = 0;
	int       n_pass = 0;
	int       n_fail = 0;
	int       cyc;
	int       i;
	int       busy_cyc;
	list_id_e src;
	list_id_e dst;
	tbl_upd_t u;
	tbl_upd_t u2;

	pgwr_mngr dut0 (
		.clk_i, .rst_ni, .init_att, .init_list, .upd_valid, .upd_pkt, .awready, .wready,
		.aw, .awvalid, .w, .wvalid, .resp, .lists, .ready, .init_att_done,
		.init_list_done, .upd_done
	);

	always #5 clk_i = ~clk_i;

	task automatic mem_write(input aw_pld_t a, input w_pld_t d);
		logic [63:0] ba;
		int b;
		for (b = 0; b < 64; b++) begin
			if (d.strb[b]) begin
				ba = a.addr + 64'(b);
				if (ba >= `PGWR_ATT_BASE && ba < `PGWR_ATT_BASE + ATT_BYTES)
					att_mem[ba - `PGWR_ATT_BASE] = d.data[b*8 +: 8];
				else if (ba >= `PGWR_LIST_BASE && ba < `PGWR_LIST_BASE + LST_BYTES)
					lst_mem[ba - `PGWR_LIST_BASE] = d.data[b*8 +: 8];
				else begin
					$display("write to unmapped address %h at %0t", ba, $time);
					err_cnt++;
				end
			end
		end
	endtask

	// little endian so byte 0 lands in the low bits
	function automatic att_entry_t att_rd(input int idx);
		logic [63:0] v;
		int k;
		for (k = 0; k < 8; k++) v[k*8 +: 8] = att_mem[(idx - 1) * 8 + k];
		att_rd = v;
	endfunction

	function automatic list_entry_t lst_rd(input int idx);
		logic [127:0] v;
		int k;
		for (k = 0; k < 16; k++) v[k*8 +: 8] = lst_mem[(idx - 1) * 16 + k];
		lst_rd = v;
	endfunction

	// sampled at the edge with ready and bvalid driven 1 ns later
	always @(posedge clk_i) begin
		aw_hs = awvalid && awready;
		w_hs = wvalid && wready;
		nxt_bvalid = 1'b0;
		if (aw_hs) addr_q.push_back(aw);
		if (w_hs) begin
			if (addr_q.size() == 0) begin
				$display("W data accepted with no address before it at %0t", $time);
				err_cnt++;
			end else begin
				mem_write(addr_q.pop_front(), w);
			end
			b_q.push_back($unsigned($random(seed)) % 4);
		end
		if (b_q.size() != 0) begin // one response at a time in order
			if (b_q[0] == 0) begin
				nxt_bvalid = 1'b1;
				b_q.delete(0);
			end else begin
				b_q[0] = b_q[0] - 1;
			end
		end
		if (aw_hs) aw_dly = $unsigned($random(seed)) % 4;
		else if (awvalid && aw_dly != 0) aw_dly = aw_dly - 1;
		if (w_hs) w_dly = $unsigned($random(seed)) % 4;
		else if (wvalid && w_dly != 0) w_dly = w_dly - 1;
		#1;
		awready = aw_dly == 0; // high ahead of valid when no delay
		wready = w_dly == 0;
		resp.bvalid = nxt_bvalid;
		resp.bresp = 2'b00; // always OKAY
	end

	task automatic check_att(input string name, input att_entry_t got, input att_entry_t exp);
		n_chk++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic check_list(input string name, input list_entry_t got, input list_entry_t exp);
		n_chk++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic check_ht(input string name, input list_ht_t got, input list_ht_t exp);
		n_chk++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		n_chk++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s got %b exp %b", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name);
		if (err_cnt == test_err0) begin
			n_pass++;
			$display("test %s: ok", name);
		end else begin
			n_fail++;
			$display("test %s: %0d errors", name, err_cnt - test_err0);
		end
		test_err0 = err_cnt;
	endtask

	// one-cycle request driven 1 ns after an edge
	task automatic strobe_req(input logic a, input logic l, input logic v, input tbl_upd_t p);
		init_att = a;
		init_list = l;
		upd_valid = v;
		upd_pkt = p;
		@(posedge clk_i);
		#1;
		init_att = 1'b0;
		init_list = 1'b0;
		upd_valid = 1'b0;
	endtask

	task automatic wait_ready();
		while (!ready) begin
			@(posedge clk_i);
			#1;
		end
	endtask

	task automatic wait_done(input int which); // 0 att init, 1 list init, 2 update
		while (!(which == 0 ? init_att_done : (which == 1 ? init_list_done : upd_done))) begin
			@(posedge clk_i);
			#1;
		end
	endtask

	// legal moves only with the incompressible list kept to half so no source runs dry
	task automatic pick_move(output list_id_e s, output list_id_e d);
		int r;
		r = $unsigned($random(seed)) % 4;
		if (r == 3 && cnt[LST_UNCOMP] != 0 && cnt[LST_INCOMP] < `PGWR_LIST_ENTRIES / 2) begin
			s = LST_UNCOMP;
			d = LST_INCOMP;
		end else if ((r == 2 && cnt[LST_UNCOMP] != 0) || cnt[LST_FREE] == 0) begin
			s = LST_UNCOMP;
			d = LST_UNCOMP;
		end else begin
			s = LST_FREE;
			d = LST_UNCOMP;
		end
	endtask

	task automatic make_upd(input list_id_e s, input list_id_e d, output tbl_upd_t p);
		p = '0; // lst_id filled in by the DUT
		p.att_id = ptr_t'($unsigned($random(seed)) % `PGWR_ATT_ENTRIES + 1);
		p.way = way_t'({$random(seed), $random(seed)});
		p.next = model_lst[model_ht.head[s]].next; // as the page-read side sees it
		p.src = s;
		p.dst = d;
	endtask

	// pop the source head and push it at the tail of UNCOMP or the head of INCOMP
	task automatic model_move(input tbl_upd_t p);
		ptr_t h;
		ptr_t t;
		att_entry_t a;
		h = model_ht.head[p.src];
		a = '0;
		a.way = p.way;
		if (p.src == LST_FREE && p.dst == LST_UNCOMP) a.sts = STS_UNCOMP;
		else if (p.src == LST_UNCOMP && p.dst == LST_INCOMP) a.sts = STS_INCOMP;
		else a.sts = STS_COMP;
		model_att[p.att_id] = a;
		if (model_ht.tail[p.src] == h) begin // last entry leaves
			model_ht.head[p.src] = NULL_PTR;
			model_ht.tail[p.src] = NULL_PTR;
		end else begin
			model_lst[p.next].prev = NULL_PTR;
			model_ht.head[p.src] = p.next;
		end
		cnt[p.src] = cnt[p.src] - 1;
		model_lst[h].att_id = p.att_id;
		if (model_ht.head[p.dst] == NULL_PTR) begin
			model_lst[h].prev = NULL_PTR;
			model_lst[h].next = NULL_PTR;
			model_ht.head[p.dst] = h;
			model_ht.tail[p.dst] = h;
		end else if (p.dst == LST_UNCOMP) begin
			t = model_ht.tail[p.dst];
			model_lst[h].prev = t;
			model_lst[h].next = NULL_PTR;
			model_lst[t].next = h;
			model_ht.tail[p.dst] = h;
		end else begin
			t = model_ht.head[p.dst];
			model_lst[h].prev = NULL_PTR;
			model_lst[h].next = t;
			model_lst[t].prev = h;
			model_ht.head[p.dst] = h;
		end
		cnt[p.dst] = cnt[p.dst] + 1;
	endtask

	initial begin
		cyc = 0;
		while (cyc < CYC_LIMIT) begin
			@(posedge clk_i);
			cyc++;
		end
		$display("timeout: run not finished within %0d cycles", CYC_LIMIT);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		rst_ni = 1'b0;
		init_att = 1'b0;
		init_list = 1'b0;
		upd_valid = 1'b0;
		upd_pkt = '0;
		for (i = 0; i < ATT_BYTES; i++) att_mem[i] = 8'(i) ^ 8'h5a; // stale contents
		for (i = 0; i < LST_BYTES; i++) lst_mem[i] = 8'(i) ^ 8'ha5;
		for (i = 1; i <= `PGWR_ATT_ENTRIES; i++) model_att[i] = '0; // DALLOC with way 0
		cnt[0] = 0;
		cnt[1] = 0;
		cnt[2] = 0;
		model_ht = '0;
		repeat (16) @(posedge clk_i);
		#1;
		rst_ni = 1'b1;

		check_flag("ready", ready, 1'b1);
		check_flag("awvalid", awvalid, 1'b0);
		check_flag("wvalid", wvalid, 1'b0);
		check_flag("upd_done", upd_done, 1'b0);
		check_flag("init_att_done", init_att_done, 1'b0);
		check_flag("init_list_done", init_list_done, 1'b0);
		check_ht("lists", lists, model_ht);
		report_test("reset");

		strobe_req(1'b1, 1'b0, 1'b0, '0);
		wait_done(0);
		wait_ready();
		check_flag("init_att_done", init_att_done, 1'b1);
		for (i = 1; i <= `PGWR_ATT_ENTRIES; i++)
			check_att($sformatf("att[%0d]", i), att_rd(i), model_att[i]);
		report_test("init_att");

		strobe_req(1'b0, 1'b1, 1'b0, '0);
		wait_done(1);
		wait_ready(); // free head and tail land one cycle after done
		for (i = 1; i <= `PGWR_LIST_ENTRIES; i++) begin
			model_lst[i] = '0;
			model_lst[i].way = way_t'(i - 1);
			model_lst[i].prev = ptr_t'(i - 1);
			model_lst[i].next = (i == `PGWR_LIST_ENTRIES) ? NULL_PTR : ptr_t'(i + 1);
		end
		model_ht.head[LST_FREE] = ptr_t'(1);
		model_ht.tail[LST_FREE] = ptr_t'(`PGWR_LIST_ENTRIES);
		cnt[LST_FREE] = `PGWR_LIST_ENTRIES;
		check_flag("init_list_done", init_list_done, 1'b1);
		check_ht("lists", lists, model_ht);
		for (i = 1; i <= `PGWR_LIST_ENTRIES; i++)
			check_list($sformatf("list[%0d]", i), lst_rd(i), model_lst[i]);
		report_test("init_list");

		for (i = 0; i < N_UPD; i++) begin
			pick_move(src, dst);
			make_upd(src, dst, u);
			wait_ready();
			strobe_req(1'b0, 1'b0, 1'b1, u);
			wait_done(2);
			model_move(u);
			wait_ready();
			check_ht($sformatf("lists after update %0d", i), lists, model_ht);
		end
		report_test("random updates");

		for (i = 1; i <= `PGWR_ATT_ENTRIES; i++)
			check_att($sformatf("att[%0d]", i), att_rd(i), model_att[i]);
		for (i = 1; i <= `PGWR_LIST_ENTRIES; i++)
			check_list($sformatf("list[%0d]", i), lst_rd(i), model_lst[i]);
		report_test("table contents");

		pick_move(src, dst);
		make_upd(src, dst, u);
		pick_move(src, dst);
		make_upd(src, dst, u2);
		wait_ready();
		strobe_req(1'b0, 1'b0, 1'b1, u);
		check_flag("ready", ready, 1'b0);
		strobe_req(1'b0, 1'b0, 1'b1, u2); // lands while busy
		wait_done(2);
		model_move(u);
		wait_ready();
		busy_cyc = 0;
		repeat (40) begin
			@(posedge clk_i);
			#1;
			if (upd_done || !ready || awvalid) busy_cyc++;
		end
		n_chk++;
		if (busy_cyc != 0) begin
			$display("request strobed while busy was acted on, DUT active %0d cycles", busy_cyc);
			err_cnt++;
		end
		check_ht("lists", lists, model_ht);
		check_att($sformatf("att[%0d]", u2.att_id), att_rd(u2.att_id), model_att[u2.att_id]);
		report_test("request while busy");

		$display("tests passed %0d failed %0d, checks %0d, errors %0d",
			n_pass, n_fail, n_chk, err_cnt);
		if (err_cnt == 0 && n_fail == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+hdl
hdl/pgwr_pkg.sv
hdl/wr_chan_hold.sv
hdl/bresp_tracker.sv
hdl/list_ht_regs.sv
hdl/init_wr_gen.sv
hdl/tbl_wr_gen.sv
hdl/pgwr_ctrl.sv
hdl/pgwr_mngr.sv
sim/tb_pgwr_mngr.sv

// File: Bender.yml
package:
  name: pgwr_mngr

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pgwr_pkg.sv
      - hdl/wr_chan_hold.sv
      - hdl/bresp_tracker.sv
      - hdl/list_ht_regs.sv
      - hdl/init_wr_gen.sv
      - hdl/tbl_wr_gen.sv
      - hdl/pgwr_ctrl.sv
      - hdl/pgwr_mngr.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/tb_pgwr_mngr.sv
